// ==== logic/gf_div_pkg.sv ====
package gf_div_pkg;

	// ------------------------------------------------------------------
	// field and polynomial sizes
	// ------------------------------------------------------------------
	localparam int coeff_w   = 16;                  // one GF(2^16) element
	localparam int num_coeff = 9;                   // degree 0 to 8
	localparam int poly_w    = coeff_w * num_coeff; // 144 bit flat word
	localparam int deg_w     = 4;                   // degree, shift and bit index

	// x^16 + x^12 + x^3 + x + 1, top bit implied
	localparam logic [coeff_w-1:0] field_poly = 16'h100B;

	// a^(2^16-2) = a^-1 for any nonzero a
	localparam logic [coeff_w-1:0] inv_exp = 16'hFFFE;

	// ------------------------------------------------------------------
	// polynomial word
	// ------------------------------------------------------------------
	// coeff[i] holds the coefficient of x^i, so coeff[0] sits in the low bits
	typedef union packed {
		logic [poly_w-1:0]                  flat;
		logic [num_coeff-1:0][coeff_w-1:0] coeff;
	} poly_u;

	// ------------------------------------------------------------------
	// division controller states
	// ------------------------------------------------------------------
	typedef enum logic [2:0] {
		st_idle   = 3'd0, // waiting for start
		st_degree = 3'd1, // check end condition, latch shift
		st_invert = 3'd2, // waiting on the inverse unit
		st_lead   = 3'd3, // quotient term from leading coefficient
		st_update = 3'd4  // subtract scaled divisor from remainder
	} div_state_e;

endpackage

// ==== logic/gf16_mul.sv ====
`timescale 1ns/1ps

module gf16_mul (
	input  logic [gf_div_pkg::coeff_w-1:0] a,
	input  logic [gf_div_pkg::coeff_w-1:0] b,
	output logic [gf_div_pkg::coeff_w-1:0] p
);

	logic [gf_div_pkg::coeff_w-1:0] acc;

	// horner style over the bits of b, msb first
	// each step doubles the partial product and folds the carry back in
	always_comb begin
		acc = '0;
		for (int i = gf_div_pkg::coeff_w - 1; i >= 0; i--) begin
			acc = {acc[gf_div_pkg::coeff_w-2:0], 1'b0} ^
				({gf_div_pkg::coeff_w{acc[gf_div_pkg::coeff_w-1]}} & gf_div_pkg::field_poly);
			if (b[i])
				acc = acc ^ a; // add a when this bit of b is set
		end
	end

	assign p = acc;

endmodule

// ==== logic/poly_mac_array.sv ====
`timescale 1ns/1ps

module poly_mac_array (
	input  logic [gf_div_pkg::coeff_w-1:0] scalar,
	input  gf_div_pkg::poly_u              operand,
	input  gf_div_pkg::poly_u              accum,
	output gf_div_pkg::poly_u              result
);

	logic [gf_div_pkg::num_coeff-1:0][gf_div_pkg::coeff_w-1:0] prod;

	// ------------------------------------------------------------------
	// one multiplier per coefficient lane
	// ------------------------------------------------------------------
	genvar i;
	generate
		for (i = 0; i < gf_div_pkg::num_coeff; i++) begin : g_lane
			gf16_mul mul_i (
				.a (scalar),
				.b (operand.coeff[i]),
				.p (prod[i])
			);
		end
	endgenerate

	// addition in GF(2^16) is xor, lane by lane
	assign result.coeff = accum.coeff ^ prod;

endmodule

// ==== logic/poly_degree.sv ====
`timescale 1ns/1ps

module poly_degree (
	input  gf_div_pkg::poly_u             poly,
	output logic [gf_div_pkg::deg_w-1:0] degree,
	output logic                          is_zero
);

	// ------------------------------------------------------------------
	// priority search, highest nonzero coefficient wins
	// ------------------------------------------------------------------
	// later (higher) hits overwrite lower ones, so the last match is the degree
	always_comb begin
		degree = '0;
		for (int i = 0; i < gf_div_pkg::num_coeff; i++) begin
			if (poly.coeff[i] != '0)
				degree = i[gf_div_pkg::deg_w-1:0];
		end
	end

	// degree reads 0 for the zero polynomial too, this tells them apart
	assign is_zero = (poly.flat == '0);

endmodule

// ==== logic/gf16_inverse.sv ====
`timescale 1ns/1ps

module gf16_inverse (
	input  logic                           clk,
	input  logic                           rst_b,
	input  logic                           inv_start,
	input  logic [gf_div_pkg::coeff_w-1:0] inv_in,
	output logic [gf_div_pkg::coeff_w-1:0] inv_out,
	output logic                           inv_done
);

	logic                           running;
	logic                           mul_phase; // 0 square, 1 conditional multiply
	logic [gf_div_pkg::deg_w-1:0]   bit_cnt;   // exponent bit, 15 down to 0
	logic [gf_div_pkg::coeff_w-1:0] acc;
	logic [gf_div_pkg::coeff_w-1:0] base;
	logic [gf_div_pkg::coeff_w-1:0] mul_b;
	logic [gf_div_pkg::coeff_w-1:0] prod;
	logic [gf_div_pkg::coeff_w-1:0] next_acc;

	// ------------------------------------------------------------------
	// shared multiplier, squares or multiplies by the base
	// ------------------------------------------------------------------
	assign mul_b = mul_phase ? base : acc;

	gf16_mul mul_i (
		.a (acc),
		.b (mul_b),
		.p (prod)
	);

	// multiply step keeps acc when the exponent bit is clear
	assign next_acc = (mul_phase && !gf_div_pkg::inv_exp[bit_cnt]) ? acc : prod;

	// last multiply cycle, result is next_acc in this same cycle
	assign inv_out  = next_acc;
	assign inv_done = running && mul_phase && (bit_cnt == '0);

	// ------------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			running   <= 1'b0;
			mul_phase <= 1'b0;
			bit_cnt   <= '0;
		end else if (inv_start) begin
			running   <= 1'b1;
			mul_phase <= 1'b0;
			bit_cnt   <= '1; // msb of the exponent first
		end else if (running) begin
			mul_phase <= !mul_phase;
			if (mul_phase) begin
				if (bit_cnt == '0)
					running <= 1'b0;
				else
					bit_cnt <= bit_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inv_start) begin
			acc  <= 16'h0001;
			base <= inv_in;
		end else if (running) begin
			acc <= next_acc;
		end
	end

endmodule

// ==== logic/poly_div_ctrl.sv ====
`timescale 1ns/1ps

module poly_div_ctrl (
	input  logic                           clk,
	input  logic                           rst_b,
	input  logic                           start,
	input  gf_div_pkg::poly_u              dividend,
	input  gf_div_pkg::poly_u              divisor,
	// degree finders
	output gf_div_pkg::poly_u              rem_poly,
	output gf_div_pkg::poly_u              div_poly,
	input  logic [gf_div_pkg::deg_w-1:0]   rem_degree,
	input  logic                           rem_zero,
	input  logic [gf_div_pkg::deg_w-1:0]   div_degree,
	input  logic                           div_zero,
	// mac array
	output logic [gf_div_pkg::coeff_w-1:0] mac_scalar,
	output gf_div_pkg::poly_u              mac_operand,
	output gf_div_pkg::poly_u              mac_accum,
	input  gf_div_pkg::poly_u              mac_result,
	// inverse unit
	output logic                           inv_start,
	output logic [gf_div_pkg::coeff_w-1:0] inv_in,
	input  logic [gf_div_pkg::coeff_w-1:0] inv_out,
	input  logic                           inv_done,
	// results
	output gf_div_pkg::poly_u              quotient,
	output gf_div_pkg::poly_u              remainder,
	output logic                           busy,
	output logic                           done,
	output logic                           div_by_zero
);

	gf_div_pkg::div_state_e         state;
	gf_div_pkg::poly_u              rem_reg;    // partial remainder
	gf_div_pkg::poly_u              dvs_reg;    // divisor, fixed for the division
	gf_div_pkg::poly_u              quot_reg;
	logic [gf_div_pkg::deg_w-1:0]   shift_reg;  // rem degree minus divisor degree
	logic [gf_div_pkg::coeff_w-1:0] inv_reg;    // inverse of divisor lead coeff
	logic [gf_div_pkg::coeff_w-1:0] scalar_reg; // current quotient term
	logic                           first_term;

	assign rem_poly  = rem_reg;
	assign div_poly  = dvs_reg;
	assign remainder = rem_reg;
	assign quotient  = quot_reg;

	// divisor does not move, so its lead coeff is stable while inv_start is up
	assign inv_in = dvs_reg.coeff[div_degree];

	// ------------------------------------------------------------------
	// mac array operands
	// ------------------------------------------------------------------
	always_comb begin
		mac_scalar  = '0;
		mac_operand = '0;
		mac_accum   = '0;
		case (state)
			gf_div_pkg::st_lead: begin
				// lane 0 only: lead coeff times inverse
				mac_scalar           = inv_reg;
				mac_operand.coeff[0] = rem_reg.coeff[rem_degree];
			end
			gf_div_pkg::st_update: begin
				mac_scalar       = scalar_reg;
				mac_operand.flat = dvs_reg.flat << (shift_reg * gf_div_pkg::coeff_w);
				mac_accum        = rem_reg;
			end
			default: begin
			end
		endcase
	end

	// ------------------------------------------------------------------
	// state machine and result registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state       <= gf_div_pkg::st_idle;
			busy        <= 1'b0;
			done        <= 1'b0;
			div_by_zero <= 1'b0;
			inv_start   <= 1'b0;
			first_term  <= 1'b0;
			rem_reg     <= '0;
			quot_reg    <= '0;
		end else begin
			done      <= 1'b0; // single cycle pulses
			inv_start <= 1'b0;
			case (state)
				gf_div_pkg::st_idle: begin
					if (start) begin
						rem_reg     <= dividend;
						quot_reg    <= '0;
						busy        <= 1'b1;
						div_by_zero <= 1'b0;
						first_term  <= 1'b1;
						state       <= gf_div_pkg::st_degree;
					end
				end
				gf_div_pkg::st_degree: begin
					if (div_zero || rem_zero || (rem_degree < div_degree)) begin
						done        <= 1'b1;
						busy        <= 1'b0;
						div_by_zero <= div_zero;
						state       <= gf_div_pkg::st_idle;
					end else if (first_term) begin
						inv_start  <= 1'b1; // one inversion per division
						first_term <= 1'b0;
						state      <= gf_div_pkg::st_invert;
					end else begin
						state <= gf_div_pkg::st_lead;
					end
				end
				gf_div_pkg::st_invert: begin
					if (inv_done)
						state <= gf_div_pkg::st_lead;
				end
				gf_div_pkg::st_lead: begin
					state <= gf_div_pkg::st_update;
				end
				gf_div_pkg::st_update: begin
					rem_reg <= mac_result; // leading term cancels here
					quot_reg.coeff[shift_reg] <= quot_reg.coeff[shift_reg] ^ scalar_reg;
					state <= gf_div_pkg::st_degree;
				end
				default: begin
					state <= gf_div_pkg::st_idle;
				end
			endcase
		end
	end

	// operand and intermediate values
	always_ff @(posedge clk) begin
		if (state == gf_div_pkg::st_idle && start)
			dvs_reg <= divisor;
		if (state == gf_div_pkg::st_degree)
			shift_reg <= rem_degree - div_degree;
		if (state == gf_div_pkg::st_invert && inv_done)
			inv_reg <= inv_out;
		if (state == gf_div_pkg::st_lead)
			scalar_reg <= mac_result.coeff[0];
	end

endmodule

// ==== logic/gf_poly_div.sv ====
`timescale 1ns/1ps

module gf_poly_div (
	input  logic              clk,
	input  logic              rst_b,
	input  logic              start,
	input  gf_div_pkg::poly_u dividend,
	input  gf_div_pkg::poly_u divisor,
	output gf_div_pkg::poly_u quotient,
	output gf_div_pkg::poly_u remainder,
	output logic              busy,
	output logic              done,
	output logic              div_by_zero
);

	gf_div_pkg::poly_u              rem_poly;
	gf_div_pkg::poly_u              div_poly;
	logic [gf_div_pkg::deg_w-1:0]   rem_degree;
	logic [gf_div_pkg::deg_w-1:0]   div_degree;
	logic                           rem_zero;
	logic                           div_zero;
	logic [gf_div_pkg::coeff_w-1:0] mac_scalar;
	gf_div_pkg::poly_u              mac_operand;
	gf_div_pkg::poly_u              mac_accum;
	gf_div_pkg::poly_u              mac_result;
	logic                           inv_start;
	logic [gf_div_pkg::coeff_w-1:0] inv_in;
	logic [gf_div_pkg::coeff_w-1:0] inv_out;
	logic                           inv_done;

	poly_div_ctrl ctrl_i (
		.clk         (clk),
		.rst_b       (rst_b),
		.start       (start),
		.dividend    (dividend),
		.divisor     (divisor),
		.rem_poly    (rem_poly),
		.div_poly    (div_poly),
		.rem_degree  (rem_degree),
		.rem_zero    (rem_zero),
		.div_degree  (div_degree),
		.div_zero    (div_zero),
		.mac_scalar  (mac_scalar),
		.mac_operand (mac_operand),
		.mac_accum   (mac_accum),
		.mac_result  (mac_result),
		.inv_start   (inv_start),
		.inv_in      (inv_in),
		.inv_out     (inv_out),
		.inv_done    (inv_done),
		.quotient    (quotient),
		.remainder   (remainder),
		.busy        (busy),
		.done        (done),
		.div_by_zero (div_by_zero)
	);

	// degree of the partial remainder
	poly_degree rem_deg_i (
		.poly    (rem_poly),
		.degree  (rem_degree),
		.is_zero (rem_zero)
	);

	// degree of the divisor
	poly_degree div_deg_i (
		.poly    (div_poly),
		.degree  (div_degree),
		.is_zero (div_zero)
	);

	poly_mac_array mac_i (
		.scalar  (mac_scalar),
		.operand (mac_operand),
		.accum   (mac_accum),
		.result  (mac_result)
	);

	gf16_inverse inv_i (
		.clk       (clk),
		.rst_b     (rst_b),
		.inv_start (inv_start),
		.inv_in    (inv_in),
		.inv_out   (inv_out),
		.inv_done  (inv_done)
	);

endmodule

// ==== verif/gf_poly_div_assertions.sv ====
`timescale 1ns/1ps

module gf_poly_div_assertions (
	input logic                   clk,
	input logic                   rst_b,
	input logic                   start,
	input gf_div_pkg::poly_u      dividend,
	input gf_div_pkg::poly_u      divisor,
	input gf_div_pkg::poly_u      quotient,
	input gf_div_pkg::poly_u      remainder,
	input logic                   busy,
	input logic                   done,
	input logic                   div_by_zero,
	input gf_div_pkg::div_state_e state
);

	int                err_cnt = 0;
	gf_div_pkg::poly_u dividend_l; // operands of the accepted start
	gf_div_pkg::poly_u divisor_l;
	logic [2*gf_div_pkg::num_coeff-2:0][gf_div_pkg::coeff_w-1:0] recomposed;
	logic [2*gf_div_pkg::num_coeff-2:0][gf_div_pkg::coeff_w-1:0] expected_wide;
	int                rem_deg;
	int                dvs_deg;
	int                n_deg;
	int                d_deg;

	// ------------------------------------------------------------------
	// reference arithmetic
	// ------------------------------------------------------------------
	function automatic logic [15:0] gf_mul(input logic [15:0] a, input logic [15:0] b);
		logic [15:0] x;
		logic [15:0] r;
		x = a;
		r = '0;
		for (int i = 0; i < gf_div_pkg::coeff_w; i++) begin
			if (b[i])
				r = r ^ x;
			x = x[15] ? ((x << 1) ^ gf_div_pkg::field_poly) : (x << 1); // times x, reduced
		end
		return r;
	endfunction

	// -1 marks the zero polynomial
	function automatic int deg_of(input gf_div_pkg::poly_u p);
		int d;
		d = -1;
		for (int i = 0; i < gf_div_pkg::num_coeff; i++) begin
			if (p.coeff[i] != '0)
				d = i;
		end
		return d;
	endfunction

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			dividend_l <= '0;
			divisor_l  <= '0;
		end else if (start && !busy) begin
			dividend_l <= dividend;
			divisor_l  <= divisor;
		end
	end

	// quotient times divisor plus remainder, full 17 coefficient width
	always_comb begin
		recomposed = '0;
		for (int i = 0; i < gf_div_pkg::num_coeff; i++) begin
			for (int j = 0; j < gf_div_pkg::num_coeff; j++)
				recomposed[i+j] = recomposed[i+j] ^ gf_mul(quotient.coeff[i], divisor_l.coeff[j]);
			recomposed[i] = recomposed[i] ^ remainder.coeff[i];
		end
		rem_deg = deg_of(remainder);
		dvs_deg = deg_of(divisor_l);
		n_deg   = deg_of(dividend);
		d_deg   = deg_of(divisor);
	end

	assign expected_wide = {128'h0, dividend_l.flat}; // upper terms must vanish

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	// first edge out of reset
	a_reset: assert property (@(posedge clk) $rose(rst_b) |->
		!busy && !done && !div_by_zero && quotient.flat == '0 && remainder.flat == '0)
		else begin $error("reset left busy, done, flags or results nonzero"); err_cnt++; end

	a_identity: assert property (@(posedge clk) disable iff (!rst_b)
		done && divisor_l.flat != '0 |-> !div_by_zero && recomposed == expected_wide)
		else begin
			$error("FAILED div_identity expected %h actual %h",
				$sampled(expected_wide), $sampled(recomposed));
			err_cnt++;
		end

	a_rem_degree: assert property (@(posedge clk) disable iff (!rst_b)
		done && divisor_l.flat != '0 |-> rem_deg < dvs_deg)
		else begin
			$error("FAILED rem_degree expected below %0d actual %0d",
				$sampled(dvs_deg), $sampled(rem_deg));
			err_cnt++;
		end

	a_zero_div: assert property (@(posedge clk) disable iff (!rst_b)
		done && divisor_l.flat == '0 |->
		div_by_zero && quotient.flat == '0 && remainder.flat == dividend_l.flat)
		else begin
			$error("FAILED zero_div expected flag 1 quotient 0 remainder %h actual %b %h %h",
				$sampled(dividend_l), $sampled(div_by_zero), $sampled(quotient),
				$sampled(remainder));
			err_cnt++;
		end

	// short division finishes 2 cycles after the accepted start
	a_short_div: assert property (@(posedge clk) disable iff (!rst_b)
		start && !busy && n_deg < d_deg |->
		##2 (done && quotient.flat == '0 && remainder.flat == dividend_l.flat))
		else begin $error("short division did not end 2 cycles after start unchanged"); err_cnt++; end

	a_unit_div: assert property (@(posedge clk) disable iff (!rst_b)
		done && divisor_l.flat == 'd1 |-> quotient.flat == dividend_l.flat && remainder.flat == '0)
		else begin
			$error("FAILED unit_div expected %h actual %h",
				$sampled(dividend_l), $sampled(quotient));
			err_cnt++;
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_b) done |=> !done)
		else begin $error("done stayed high for two cycles"); err_cnt++; end

	a_done_source: assert property (@(posedge clk) disable iff (!rst_b)
		done |-> $past(busy) && !busy && state == gf_div_pkg::st_idle)
		else begin $error("done without a running division"); err_cnt++; end

	a_busy_rise: assert property (@(posedge clk) disable iff (!rst_b) start && !busy |=> busy)
		else begin $error("busy did not rise after an accepted start"); err_cnt++; end

endmodule

// ==== verif/gf_poly_div_tb.sv ====
`timescale 1ns/1ps

module gf_poly_div_tb;

	logic              clk = 1'b0;
	logic              rst_b;
	logic              start;
	gf_div_pkg::poly_u dividend;
	gf_div_pkg::poly_u divisor;
	gf_div_pkg::poly_u quotient;
	gf_div_pkg::poly_u remainder;
	logic              busy;
	logic              done;
	logic              div_by_zero;
	int                timeouts = 0;

	always #5 clk = ~clk;

	gf_poly_div gf_poly_div_i (.*);

	bind gf_poly_div gf_poly_div_assertions chk_i (.*, .state(ctrl_i.state));

	// deg -1 gives the zero polynomial, dense keeps every term nonzero
	function automatic gf_div_pkg::poly_u random_poly(input int deg, input bit dense);
		gf_div_pkg::poly_u p;
		p = '0;
		for (int i = 0; i <= deg; i++) begin
			p.coeff[i] = 16'($urandom());
			if ((dense || i == deg) && p.coeff[i] == '0)
				p.coeff[i] = 16'h0001; // keeps the degree exact
		end
		return p;
	endfunction

	// ------------------------------------------------------------------
	// one division, optional ignored start while busy
	// ------------------------------------------------------------------
	task automatic run_div(input string name, input gf_div_pkg::poly_u n,
		input gf_div_pkg::poly_u d, input bit poke);
		int cnt;
		@(posedge clk);
		dividend <= n;
		divisor  <= d;
		start    <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (poke) begin
			@(posedge clk);
			dividend.flat <= ~n.flat; // must not reach the running division
			divisor       <= random_poly(3, 1'b0);
			start         <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		cnt = 0;
		@(negedge clk);
		while (!done && cnt < 400) begin
			@(negedge clk);
			cnt++;
		end
		if (!done) begin
			$display("timeout in test %s, done did not arrive within %0d cycles", name, cnt);
			timeouts++;
		end
	endtask

	initial begin
		int dn;
		int dd;
		int errors;
		void'($urandom(19018));
		rst_b    = 1'b0;
		start    = 1'b0;
		dividend = '0;
		divisor  = '0;
		repeat (5) @(posedge clk);
		rst_b <= 1'b1;

		// directed cases
		run_div("zero_divisor", random_poly(5, 1'b0), '0, 1'b0);
		run_div("zero_both", '0, '0, 1'b0);
		run_div("low_dividend", random_poly(2, 1'b0), random_poly(5, 1'b0), 1'b0);
		run_div("zero_dividend", '0, random_poly(3, 1'b0), 1'b0);
		run_div("unit_divisor", random_poly(8, 1'b1), gf_div_pkg::poly_u'(1), 1'b1);
		run_div("unit_const", random_poly(0, 1'b1), gf_div_pkg::poly_u'(1), 1'b0);
		run_div("equal_degree", random_poly(8, 1'b0), random_poly(8, 1'b0), 1'b0);
		run_div("linear_divisor", random_poly(8, 1'b1), random_poly(1, 1'b1), 1'b1);

		// random degrees, every fourth long division gets a start while busy
		for (int i = 0; i < 40; i++) begin
			dn = int'($urandom_range(9, 0)) - 1;
			dd = int'($urandom_range(8, 0));
			run_div("random", random_poly(dn, 1'b0), random_poly(dd, 1'b0),
				(i % 4 == 0) && (dn >= dd));
		end

		repeat (3) @(posedge clk);
		errors = gf_poly_div_i.chk_i.err_cnt + timeouts;
		$display("assertion errors: %0d, timeouts: %0d", gf_poly_div_i.chk_i.err_cnt, timeouts);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== flist.f ====
logic/gf_div_pkg.sv
logic/gf16_mul.sv
logic/poly_mac_array.sv
logic/poly_degree.sv
logic/gf16_inverse.sv
logic/poly_div_ctrl.sv
logic/gf_poly_div.sv
verif/gf_poly_div_assertions.sv
verif/gf_poly_div_tb.sv
